// File: rtl/ooo_consts.svh
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// Live ROB entries, tags 1 to 7
`define ROB_ENTRIES 7

// Tag 0 marks a ready operand
`define TAG_W 3

// Decoded op for an empty slot
`define OP_NONE 4'd0

`endif

// File: rtl/ooo_pkg.sv
`include "ooo_consts.svh"

package ooo_pkg;

    typedef enum logic [3:0] {
        OP_NOP  = `OP_NONE,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_ADDI,
        OP_LUI,
        OP_BEQ,
        OP_BNE
    } alu_op_e;

    typedef logic [`TAG_W-1:0] rob_tag_t;

    // R view also serves branches
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } insn_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_i_t;

    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } insn_u_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
        insn_u_t u;
    } insn_word_u;

    typedef struct packed {
        alu_op_e     op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        logic        uses_imm;
    } decoded_insn_t;

endpackage

// File: rtl/issue_if.sv
`timescale 1ns/1ns

interface issue_if;
    import ooo_pkg::*;

    logic        valid;
    alu_op_e     op;
    rob_tag_t    tag;
    logic [31:0] val1;
    logic [31:0] val2;
    // Waiting tags, 0 when the value is present
    rob_tag_t    q1;
    rob_tag_t    q2;

    modport rob (
        output valid, op, tag, val1, val2, q1, q2
    );

    modport exec (
        input valid, op, tag, val1, val2, q1, q2
    );
endinterface

// File: rtl/cdb_if.sv
`timescale 1ns/1ns

interface cdb_if;
    import ooo_pkg::*;

    logic        valid;
    rob_tag_t    tag;
    logic [31:0] value;
    logic        is_branch;
    logic        taken;

    modport drive (
        output valid, tag, value, is_branch, taken
    );

    modport snoop (
        input valid, tag, value, is_branch, taken
    );
endinterface

// File: rtl/insn_decode.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module insn_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   insn_valid,
    input  ooo_pkg::insn_word_u    insn,
    output ooo_pkg::decoded_insn_t dec
);
    import ooo_pkg::*;

    localparam logic [6:0] OPC_R   = 7'b0110011;
    localparam logic [6:0] OPC_I   = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_BR  = 7'b1100011;

    decoded_insn_t nxt;

    always_comb begin
        nxt    = '0;
        nxt.op = alu_op_e'(`OP_NONE);
        if (insn_valid) begin
            case (insn.r.opcode)
                OPC_R: begin
                    nxt.rd  = insn.r.rd;
                    nxt.rs1 = insn.r.rs1;
                    nxt.rs2 = insn.r.rs2;
                    case ({insn.r.funct7, insn.r.funct3})
                        {7'h00, 3'b000}: nxt.op = OP_ADD;
                        {7'h20, 3'b000}: nxt.op = OP_SUB;
                        {7'h00, 3'b111}: nxt.op = OP_AND;
                        {7'h00, 3'b110}: nxt.op = OP_OR;
                        {7'h00, 3'b100}: nxt.op = OP_XOR;
                        {7'h00, 3'b010}: nxt.op = OP_SLT;
                        default: ;
                    endcase
                end
                OPC_I: begin
                    if (insn.i.funct3 == 3'b000) begin
                        nxt.op       = OP_ADDI;
                        nxt.rd       = insn.i.rd;
                        nxt.rs1      = insn.i.rs1;
                        nxt.imm      = {{20{insn.i.imm12[11]}}, insn.i.imm12};
                        nxt.uses_imm = 1'b1;
                    end
                end
                OPC_LUI: begin
                    nxt.op       = OP_LUI;
                    nxt.rd       = insn.u.rd;
                    nxt.imm      = {insn.u.imm20, 12'b0};
                    nxt.uses_imm = 1'b1;
                end
                OPC_BR: begin
                    // rd bits hold the offset, so rd stays 0
                    nxt.rs1 = insn.r.rs1;
                    nxt.rs2 = insn.r.rs2;
                    if (insn.r.funct3 == 3'b000) begin
                        nxt.op = OP_BEQ;
                    end else if (insn.r.funct3 == 3'b001) begin
                        nxt.op = OP_BNE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec.op <= alu_op_e'(`OP_NONE);
        end else begin
            dec <= nxt;
        end
    end

    a_branch_no_rd: assert property (@(posedge clk) disable iff (!rst)
        insn_valid && insn.r.opcode == OPC_BR |=> dec.rd == 5'd0);

endmodule

// File: rtl/reorder_buffer.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module reorder_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  ooo_pkg::decoded_insn_t dec,
    output logic [4:0]             rd_num1,
    output logic [4:0]             rd_num2,
    input  logic [31:0]            rf_val1,
    input  logic [31:0]            rf_val2,
    input  ooo_pkg::rob_tag_t      rf_tag1,
    input  ooo_pkg::rob_tag_t      rf_tag2,
    output logic                   rename_valid,
    output logic [4:0]             rename_rd,
    output ooo_pkg::rob_tag_t      rename_tag,
    output logic                   retire_valid,
    output logic [4:0]             retire_rd,
    output ooo_pkg::rob_tag_t      retire_tag,
    output logic [31:0]            retire_value,
    output logic                   retire_branch,
    output logic                   retire_taken,
    issue_if.rob                   issue,
    cdb_if.snoop                   cdb
);
    import ooo_pkg::*;

    alu_op_e           e_op    [1:`ROB_ENTRIES];
    logic [4:0]        e_rd    [1:`ROB_ENTRIES];
    logic [31:0]       e_value [1:`ROB_ENTRIES];
    logic              e_taken [1:`ROB_ENTRIES];
    logic              e_busy  [1:`ROB_ENTRIES];
    logic              e_done  [1:`ROB_ENTRIES];
    rob_tag_t          head;
    rob_tag_t          tail;
    logic [`TAG_W-1:0] count;
    logic              alloc;
    logic              alloc_done;
    logic              retire;
    rob_tag_t          q1;
    rob_tag_t          q2;
    logic [31:0]       v1;
    logic [31:0]       v2;

    function automatic rob_tag_t next_tag(input rob_tag_t t);
        return (t == rob_tag_t'(`ROB_ENTRIES)) ? rob_tag_t'(1) : t + 1'b1;
    endfunction

    // Register file, then finished entry, then this cycle's broadcast
    function automatic void resolve(input rob_tag_t tag_in, input logic [31:0] rf_val,
                                    output rob_tag_t tag_out, output logic [31:0] val_out);
        tag_out = tag_in;
        val_out = rf_val;
        if (tag_in != '0) begin
            if (e_done[tag_in]) begin
                tag_out = '0;
                val_out = e_value[tag_in];
            end else if (cdb.valid && cdb.tag == tag_in) begin
                tag_out = '0;
                val_out = cdb.value;
            end else begin
                val_out = '0;
            end
        end
    endfunction

    assign alloc        = dec.op != alu_op_e'(`OP_NONE);
    assign retire       = e_busy[head] && e_done[head];
    assign rd_num1      = dec.rs1;
    assign rd_num2      = dec.rs2;
    assign rename_valid = alloc && dec.rd != 5'd0;
    assign rename_rd    = dec.rd;
    assign rename_tag   = tail;

    always_comb begin
        resolve(rf_tag1, rf_val1, q1, v1);
        resolve(rf_tag2, rf_val2, q2, v2);
        if (dec.uses_imm) begin
            q2 = '0;
            v2 = dec.imm;
        end
    end

    // LUI and ready ADDI finish here and skip the execute stage
    assign alloc_done = dec.op == OP_LUI || (dec.op == OP_ADDI && q1 == '0);

    always_ff @(posedge clk) begin
        if (!rst) begin
            head         <= rob_tag_t'(1);
            tail         <= rob_tag_t'(1);
            count        <= '0;
            retire_valid <= 1'b0;
            issue.valid  <= 1'b0;
            for (int i = 1; i <= `ROB_ENTRIES; i++) begin
                e_busy[i] <= 1'b0;
                e_done[i] <= 1'b0;
            end
        end else begin
            if (cdb.valid) begin
                e_done[cdb.tag] <= 1'b1;
            end
            if (retire) begin
                e_busy[head] <= 1'b0;
                e_done[head] <= 1'b0;
                head         <= next_tag(head);
            end
            if (alloc) begin
                e_busy[tail] <= 1'b1;
                e_done[tail] <= alloc_done;
                tail         <= next_tag(tail);
            end
            case ({alloc, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            retire_valid <= retire;
            issue.valid  <= alloc && !alloc_done;
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            e_value[cdb.tag] <= cdb.value;
            e_taken[cdb.tag] <= cdb.is_branch && cdb.taken;
        end
        if (alloc) begin
            e_op[tail]    <= dec.op;
            e_rd[tail]    <= dec.rd;
            e_value[tail] <= (dec.op == OP_LUI) ? dec.imm : v1 + dec.imm;
            e_taken[tail] <= 1'b0;
        end
        issue.op   <= dec.op;
        issue.tag  <= tail;
        issue.val1 <= v1;
        issue.val2 <= v2;
        issue.q1   <= q1;
        issue.q2   <= q2;
        if (retire) begin
            retire_rd     <= e_rd[head];
            retire_tag    <= head;
            retire_value  <= e_value[head];
            retire_branch <= e_op[head] inside {OP_BEQ, OP_BNE};
            retire_taken  <= e_taken[head];
        end
    end

    // Sender credits keep the buffer from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        alloc |-> count != `ROB_ENTRIES);

    a_cdb_live_tag: assert property (@(posedge clk) disable iff (!rst)
        cdb.valid |-> e_busy[cdb.tag]);

endmodule

// File: rtl/alu_execute.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module alu_execute (
    input  logic  clk,
    input  logic  rst,
    issue_if.exec issue,
    cdb_if.drive  cdb
);
    import ooo_pkg::*;

    localparam int SLOTS = `ROB_ENTRIES;
    localparam int SEL_W = $clog2(SLOTS + 1);

    // Slot 0 is the oldest, the station compacts on each fire
    logic             s_valid [SLOTS];
    alu_op_e          s_op    [SLOTS];
    rob_tag_t         s_tag   [SLOTS];
    logic [31:0]      s_v1    [SLOTS];
    logic [31:0]      s_v2    [SLOTS];
    rob_tag_t         s_q1    [SLOTS];
    rob_tag_t         s_q2    [SLOTS];
    logic [SEL_W-1:0] src     [SLOTS];
    logic             keep    [SLOTS];
    logic [SEL_W-1:0] sel;
    logic [SEL_W-1:0] ins_pos;
    logic             slot_fire;
    logic             new_fire;
    logic             ins;
    logic             full;
    alu_op_e          ex_op;
    rob_tag_t         ex_tag;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      result;
    logic             taken;

    function automatic logic hit(input rob_tag_t q);
        return cdb.valid && q != '0 && q == cdb.tag;
    endfunction

    always_comb begin
        slot_fire = 1'b0;
        sel       = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            if (s_valid[i] && s_q1[i] == '0 && s_q2[i] == '0) begin
                slot_fire = 1'b1;
                sel       = SEL_W'(i);
            end
        end
        full    = 1'b1;
        ins_pos = SEL_W'(SLOTS);
        for (int i = SLOTS - 1; i >= 0; i--) begin
            src[i]  = SEL_W'(i);
            keep[i] = s_valid[i];
            if (slot_fire && i >= sel) begin
                src[i]  = (i < SLOTS - 1) ? SEL_W'(i + 1) : SEL_W'(i);
                keep[i] = (i < SLOTS - 1) ? s_valid[i + 1] : 1'b0;
            end
            full = full && s_valid[i];
            if (!keep[i]) begin
                ins_pos = SEL_W'(i);
            end
        end
    end

    // A ready issue goes straight to the ALU when no slot is ready
    assign new_fire = issue.valid && !slot_fire && issue.q1 == '0 && issue.q2 == '0;
    assign ins      = issue.valid && !new_fire;

    assign ex_op  = slot_fire ? s_op[sel]  : issue.op;
    assign ex_tag = slot_fire ? s_tag[sel] : issue.tag;
    assign a      = slot_fire ? s_v1[sel]  : issue.val1;
    assign b      = slot_fire ? s_v2[sel]  : issue.val2;

    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (ex_op)
            OP_ADD, OP_ADDI: result = a + b;
            OP_SUB:          result = a - b;
            OP_AND:          result = a & b;
            OP_OR:           result = a | b;
            OP_XOR:          result = a ^ b;
            OP_SLT:          result = {31'b0, $signed(a) < $signed(b)};
            OP_BEQ:          taken  = a == b;
            OP_BNE:          taken  = a != b;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            cdb.valid <= 1'b0;
            for (int i = 0; i < SLOTS; i++) begin
                s_valid[i] <= 1'b0;
            end
        end else begin
            cdb.valid <= slot_fire || new_fire;
            for (int i = 0; i < SLOTS; i++) begin
                s_valid[i] <= keep[i] || (ins && ins_pos == SEL_W'(i));
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SLOTS; i++) begin
            s_op[i]  <= s_op[src[i]];
            s_tag[i] <= s_tag[src[i]];
            s_v1[i]  <= hit(s_q1[src[i]]) ? cdb.value : s_v1[src[i]];
            s_q1[i]  <= hit(s_q1[src[i]]) ? '0 : s_q1[src[i]];
            s_v2[i]  <= hit(s_q2[src[i]]) ? cdb.value : s_v2[src[i]];
            s_q2[i]  <= hit(s_q2[src[i]]) ? '0 : s_q2[src[i]];
            if (ins && ins_pos == SEL_W'(i)) begin
                s_op[i]  <= issue.op;
                s_tag[i] <= issue.tag;
                s_v1[i]  <= hit(issue.q1) ? cdb.value : issue.val1;
                s_q1[i]  <= hit(issue.q1) ? '0 : issue.q1;
                s_v2[i]  <= hit(issue.q2) ? cdb.value : issue.val2;
                s_q2[i]  <= hit(issue.q2) ? '0 : issue.q2;
            end
        end
        cdb.tag       <= ex_tag;
        cdb.value     <= result;
        cdb.is_branch <= ex_op inside {OP_BEQ, OP_BNE};
        cdb.taken     <= taken;
    end

    a_station_room: assert property (@(posedge clk) disable iff (!rst)
        issue.valid |-> !full);

endmodule

// File: rtl/reg_status_file.sv
`timescale 1ns/1ns

module reg_status_file (
    input  logic              clk,
    input  logic              rst,
    input  logic [4:0]        rd_num1,
    input  logic [4:0]        rd_num2,
    output logic [31:0]       rf_val1,
    output logic [31:0]       rf_val2,
    output ooo_pkg::rob_tag_t rf_tag1,
    output ooo_pkg::rob_tag_t rf_tag2,
    input  logic              rename_valid,
    input  logic [4:0]        rename_rd,
    input  ooo_pkg::rob_tag_t rename_tag,
    input  logic              retire_valid,
    input  logic [4:0]        retire_rd,
    input  ooo_pkg::rob_tag_t retire_tag,
    input  logic [31:0]       retire_value
);
    import ooo_pkg::*;

    logic [31:0] regs [32];
    rob_tag_t    pend [32];
    logic        retire_wr;

    assign retire_wr = retire_valid && retire_rd != 5'd0;

    // The retiring entry is already freed in the ROB, so bypass it
    function automatic void read_port(input logic [4:0] num,
                                      output logic [31:0] val, output rob_tag_t tag);
        val = regs[num];
        tag = pend[num];
        if (num == 5'd0) begin
            val = '0;
            tag = '0;
        end else if (retire_wr && retire_rd == num && pend[num] == retire_tag) begin
            val = retire_value;
            tag = '0;
        end
    endfunction

    always_comb begin
        read_port(rd_num1, rf_val1, rf_tag1);
        read_port(rd_num2, rf_val2, rf_tag2);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                pend[i] <= '0;
            end
        end else begin
            if (retire_wr && pend[retire_rd] == retire_tag) begin
                pend[retire_rd] <= '0;
            end
            // Newer rename wins
            if (rename_valid) begin
                pend[rename_rd] <= rename_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire_wr) begin
            regs[retire_rd] <= retire_value;
        end
    end

    a_x0_never_pending: assert property (@(posedge clk) disable iff (!rst)
        pend[0] == '0);

endmodule

// File: rtl/ooo_core.sv
`timescale 1ns/1ns

module ooo_core (
    input  logic        clk,
    input  logic        rst,
    input  logic        insn_valid,
    input  logic [31:0] insn,
    output logic        retire_valid,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_value,
    output logic        retire_branch,
    output logic        retire_taken
);
    import ooo_pkg::*;

    decoded_insn_t dec;
    logic [4:0]    rd_num1;
    logic [4:0]    rd_num2;
    logic [31:0]   rf_val1;
    logic [31:0]   rf_val2;
    rob_tag_t      rf_tag1;
    rob_tag_t      rf_tag2;
    logic          rename_valid;
    logic [4:0]    rename_rd;
    rob_tag_t      rename_tag;
    rob_tag_t      retire_tag;

    issue_if u_issue ();
    cdb_if   u_cdb ();

    insn_decode u_insn_decode (
        .clk        (clk),
        .rst        (rst),
        .insn_valid (insn_valid),
        .insn       (insn),
        .dec        (dec)
    );

    reorder_buffer u_reorder_buffer (
        .clk           (clk),
        .rst           (rst),
        .dec           (dec),
        .rd_num1       (rd_num1),
        .rd_num2       (rd_num2),
        .rf_val1       (rf_val1),
        .rf_val2       (rf_val2),
        .rf_tag1       (rf_tag1),
        .rf_tag2       (rf_tag2),
        .rename_valid  (rename_valid),
        .rename_rd     (rename_rd),
        .rename_tag    (rename_tag),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_tag    (retire_tag),
        .retire_value  (retire_value),
        .retire_branch (retire_branch),
        .retire_taken  (retire_taken),
        .issue         (u_issue.rob),
        .cdb           (u_cdb.snoop)
    );

    alu_execute u_alu_execute (
        .clk   (clk),
        .rst   (rst),
        .issue (u_issue.exec),
        .cdb   (u_cdb.drive)
    );

    reg_status_file u_reg_status_file (
        .clk          (clk),
        .rst          (rst),
        .rd_num1      (rd_num1),
        .rd_num2      (rd_num2),
        .rf_val1      (rf_val1),
        .rf_val2      (rf_val2),
        .rf_tag1      (rf_tag1),
        .rf_tag2      (rf_tag2),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_tag   (rename_tag),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_tag   (retire_tag),
        .retire_value (retire_value)
    );

endmodule

// File: test/clk_gen.sv
`timescale 1ns/1ns

module clk_gen (
    output logic clk
);
    // 100 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #50;
        clk = ~clk;
    end
endmodule

// File: test/tb_ooo_core.sv
`timescale 1ns/1ns
`include "ooo_consts.svh"

module tb_ooo_core;

    localparam int MAX_ROWS = 40;
    localparam int TIMEOUT  = 100;

    // R-type {funct7, funct3}
    localparam logic [9:0] FN_ADD = {7'h00, 3'b000};
    localparam logic [9:0] FN_SUB = {7'h20, 3'b000};
    localparam logic [9:0] FN_AND = {7'h00, 3'b111};
    localparam logic [9:0] FN_OR  = {7'h00, 3'b110};
    localparam logic [9:0] FN_XOR = {7'h00, 3'b100};
    localparam logic [9:0] FN_SLT = {7'h00, 3'b010};

    // Row flags {branch, taken, burst}
    localparam logic [2:0] PLAIN     = 3'b000;
    localparam logic [2:0] NOT_TAKEN = 3'b100;
    localparam logic [2:0] TAKEN     = 3'b110;
    localparam logic [2:0] BURST     = 3'b001;

    logic        clk;
    logic        rst;
    logic        insn_valid;
    logic [31:0] insn;
    logic        retire_valid;
    logic [4:0]  retire_rd;
    logic [31:0] retire_value;
    logic        retire_branch;
    logic        retire_taken;

    string       row_name  [MAX_ROWS];
    logic [31:0] row_word  [MAX_ROWS];
    logic [4:0]  row_rd    [MAX_ROWS];
    logic [31:0] row_value [MAX_ROWS];
    logic [2:0]  row_flags [MAX_ROWS];
    int          num_rows;
    int          credits;
    logic        burst_stalled;

    clk_gen u_clk_gen (
        .clk (clk)
    );

    ooo_core u_ooo_core (
        .clk           (clk),
        .rst           (rst),
        .insn_valid    (insn_valid),
        .insn          (insn),
        .retire_valid  (retire_valid),
        .retire_rd     (retire_rd),
        .retire_value  (retire_value),
        .retire_branch (retire_branch),
        .retire_taken  (retire_taken)
    );

    function automatic logic [31:0] r_type_word(input logic [9:0] fn, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // Offset 8 sits in the rd bits
    function automatic logic [31:0] branch_word(input logic [2:0] funct3,
                                                input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'h00, rs2, rs1, funct3, 5'd8, 7'b1100011};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("[FAIL] %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic add_row(input string name, input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] value, input logic [2:0] flags);
        row_name[num_rows]  = name;
        row_word[num_rows]  = word;
        row_rd[num_rows]    = rd;
        row_value[num_rows] = value;
        row_flags[num_rows] = flags;
        num_rows++;
    endtask

    task automatic build_table();
        // Operand setup and every R-type op
        add_row("lui x1", lui_word(5'd1, 20'h12345), 5'd1, 32'h12345000, PLAIN);
        add_row("addi x1", addi_word(5'd1, 5'd1, 12'h678), 5'd1, 32'h12345678, PLAIN);
        add_row("addi x2", addi_word(5'd2, 5'd0, 12'hff0), 5'd2, 32'hfffffff0, PLAIN);
        add_row("addi x3", addi_word(5'd3, 5'd0, 12'h003), 5'd3, 32'h00000003, PLAIN);
        add_row("add x4", r_type_word(FN_ADD, 5'd4, 5'd1, 5'd3), 5'd4, 32'h1234567b, PLAIN);
        add_row("sub x5", r_type_word(FN_SUB, 5'd5, 5'd3, 5'd2), 5'd5, 32'h00000013, PLAIN);
        add_row("and x6", r_type_word(FN_AND, 5'd6, 5'd1, 5'd2), 5'd6, 32'h12345670, PLAIN);
        add_row("or x7", r_type_word(FN_OR, 5'd7, 5'd3, 5'd2), 5'd7, 32'hfffffff3, PLAIN);
        add_row("xor x8", r_type_word(FN_XOR, 5'd8, 5'd1, 5'd2), 5'd8, 32'hedcba988, PLAIN);
        add_row("slt x9", r_type_word(FN_SLT, 5'd9, 5'd2, 5'd3), 5'd9, 32'd1, PLAIN);
        add_row("slt x10", r_type_word(FN_SLT, 5'd10, 5'd3, 5'd2), 5'd10, 32'd0, PLAIN);
        add_row("addi x11", addi_word(5'd11, 5'd0, 12'hfff), 5'd11, 32'hffffffff, PLAIN);
        add_row("slt x12", r_type_word(FN_SLT, 5'd12, 5'd2, 5'd11), 5'd12, 32'd1, PLAIN);
        // RAW chain on x13
        add_row("chain 1", addi_word(5'd13, 5'd0, 12'h001), 5'd13, 32'd1, PLAIN);
        add_row("chain 2", addi_word(5'd13, 5'd13, 12'h002), 5'd13, 32'd3, PLAIN);
        add_row("chain 3", r_type_word(FN_ADD, 5'd13, 5'd13, 5'd13), 5'd13, 32'd6, PLAIN);
        add_row("chain 4", r_type_word(FN_SUB, 5'd13, 5'd13, 5'd3), 5'd13, 32'd3, PLAIN);
        add_row("chain 5", addi_word(5'd13, 5'd13, 12'd100), 5'd13, 32'h00000067, PLAIN);
        add_row("chain 6", r_type_word(FN_XOR, 5'd13, 5'd13, 5'd1), 5'd13, 32'h1234561f, PLAIN);
        // Branches and writes aimed at x0
        add_row("beq equal", branch_word(3'b000, 5'd3, 5'd3), 5'd0, 32'd0, TAKEN);
        add_row("beq differ", branch_word(3'b000, 5'd1, 5'd2), 5'd0, 32'd0, NOT_TAKEN);
        add_row("bne differ", branch_word(3'b001, 5'd1, 5'd2), 5'd0, 32'd0, TAKEN);
        add_row("bne equal", branch_word(3'b001, 5'd11, 5'd11), 5'd0, 32'd0, NOT_TAKEN);
        add_row("addi x0", addi_word(5'd0, 5'd0, 12'h005), 5'd0, 32'd5, PLAIN);
        add_row("lui x0", lui_word(5'd0, 20'habcde), 5'd0, 32'habcde000, PLAIN);
        add_row("add x14", r_type_word(FN_ADD, 5'd14, 5'd0, 5'd3), 5'd14, 32'd3, PLAIN);
        add_row("beq x0", branch_word(3'b000, 5'd0, 5'd0), 5'd0, 32'd0, TAKEN);
        // Dependent burst that retires slower than it is sent
        add_row("burst 0", r_type_word(FN_ADD, 5'd15, 5'd3, 5'd3), 5'd15, 32'd6, BURST);
        add_row("burst 1", r_type_word(FN_ADD, 5'd16, 5'd15, 5'd3), 5'd16, 32'd9, BURST);
        add_row("burst 2", r_type_word(FN_ADD, 5'd17, 5'd16, 5'd16), 5'd17, 32'd18, BURST);
        add_row("burst 3", r_type_word(FN_SUB, 5'd18, 5'd17, 5'd3), 5'd18, 32'd15, BURST);
        add_row("burst 4", r_type_word(FN_XOR, 5'd19, 5'd18, 5'd3), 5'd19, 32'd12, BURST);
        add_row("burst 5", r_type_word(FN_OR, 5'd20, 5'd19, 5'd3), 5'd20, 32'd15, BURST);
        add_row("burst 6", r_type_word(FN_AND, 5'd21, 5'd20, 5'd2), 5'd21, 32'd0, BURST);
        add_row("burst 7", r_type_word(FN_SLT, 5'd22, 5'd21, 5'd20), 5'd22, 32'd1, BURST);
        add_row("burst 8", r_type_word(FN_ADD, 5'd23, 5'd22, 5'd19), 5'd23, 32'd13, BURST);
        add_row("burst 9", r_type_word(FN_SUB, 5'd24, 5'd23, 5'd20), 5'd24, 32'hfffffffe, BURST);
    endtask

    task automatic wait_for_credits(input int need, input logic in_burst);
        int waited;
        waited = 0;
        while (credits < need) begin
            if (in_burst && need == 1) begin
                burst_stalled = 1'b1;
            end
            @(posedge clk);
            #10;
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("Sender waited too long for a credit to come back");
            end
        end
    endtask

    task automatic send_rows();
        int   gap;
        logic burst;
        for (int i = 0; i < num_rows; i++) begin
            burst = row_flags[i][0];
            if (burst && (i == 0 || !row_flags[i - 1][0])) begin
                // Burst starts with all credits home
                wait_for_credits(`ROB_ENTRIES, 1'b0);
            end
            gap = burst ? 0 : int'($urandom % 3);
            repeat (gap) begin
                @(posedge clk);
                #10;
            end
            wait_for_credits(1, burst);
            insn_valid = 1'b1;
            insn       = row_word[i];
            credits--;
            @(posedge clk);
            #10;
            insn_valid = 1'b0;
        end
    endtask

    task automatic wait_for_retire();
        int waited;
        waited = 0;
        @(negedge clk);
        while (retire_valid !== 1'b1) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                stop_run("No retirement came out of the core in time");
            end
        end
    endtask

    task automatic check_rows();
        for (int i = 0; i < num_rows; i++) begin
            wait_for_retire();
            check_equal({row_name[i], " rd"}, row_rd[i], retire_rd);
            check_equal({row_name[i], " value"}, row_value[i], retire_value);
            check_equal({row_name[i], " branch"}, row_flags[i][2], retire_branch);
            check_equal({row_name[i], " taken"}, row_flags[i][1], retire_taken);
            credits++;
        end
    endtask

    initial begin
        void'($urandom(32'hc2f47938));
        rst           = 1'b0;
        insn_valid    = 1'b0;
        insn          = '0;
        credits       = `ROB_ENTRIES;
        burst_stalled = 1'b0;
        num_rows      = 0;
        build_table();
        repeat (5) begin
            @(posedge clk);
        end
        #10;
        rst = 1'b1;
        // Nothing sent yet
        repeat (10) begin
            @(negedge clk);
            check_equal("idle after reset", 32'd0, retire_valid);
        end
        @(posedge clk);
        #10;
        fork
            send_rows();
            check_rows();
        join
        repeat (10) begin
            @(negedge clk);
            check_equal("extra retirement", 32'd0, retire_valid);
        end
        check_equal("burst stalled on credits", 32'd1, burst_stalled);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: all.f
+incdir+rtl
rtl/ooo_pkg.sv
rtl/issue_if.sv
rtl/cdb_if.sv
rtl/insn_decode.sv
rtl/reorder_buffer.sv
rtl/alu_execute.sv
rtl/reg_status_file.sv
rtl/ooo_core.sv
test/clk_gen.sv
test/tb_ooo_core.sv

// File: Bender.yml
package:
  name: ooo_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ooo_pkg.sv
      - rtl/issue_if.sv
      - rtl/cdb_if.sv
      - rtl/insn_decode.sv
      - rtl/reorder_buffer.sv
      - rtl/alu_execute.sv
      - rtl/reg_status_file.sv
      - rtl/ooo_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/clk_gen.sv
      - test/tb_ooo_core.sv
